/* src/sad_pkg.sv */
package sad_pkg;

    // geometry of one search block
    localparam int PIXEL_W   = 8;
    localparam int BLOCK_DIM = 8;                    // row length and number of grid rows
    localparam int NUM_PE    = BLOCK_DIM * BLOCK_DIM;
    localparam int ROW_W     = BLOCK_DIM * PIXEL_W;

    // accumulator widths sized for the worst case of all pixels at 255
    localparam int ROW_SUM_W = 11;                   // 8 x 255 = 2040
    localparam int SAD_W     = 14;                   // 64 x 255 = 16320

    // fill counter runs from 0 up to BLOCK_DIM and then saturates
    localparam int FILL_W    = 4;

    // one pixel or one absolute difference
    typedef logic [PIXEL_W-1:0] pixel_t;

    // a row of BLOCK_DIM pixels with the leftmost pixel in the top bits
    typedef logic [ROW_W-1:0] pix_row_t;

    // sum of the differences of one grid row
    typedef logic [ROW_SUM_W-1:0] row_sum_t;

    // sum of absolute differences of the whole block
    typedef logic [SAD_W-1:0] sad_t;

    // number of rows shifted into the grid since reset
    typedef logic [FILL_W-1:0] fill_cnt_t;

endpackage

/* src/sad_pe.sv */
`timescale 1ns/1ps

module sad_pe
    import sad_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   crt_keep_i,
    input  pixel_t crt_pixel_i,
    input  pixel_t pre_pixel_i,
    output pixel_t crt_pixel_o,
    output pixel_t pre_pixel_o,
    output pixel_t abs_diff_o
);

    pixel_t crt_q;
    pixel_t pre_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            crt_q <= '0;
            pre_q <= '0;
        end else begin
            pre_q <= pre_pixel_i;                    // reference pixels always move on
            if (!crt_keep_i) begin
                crt_q <= crt_pixel_i;
            end
        end
    end

    assign crt_pixel_o = crt_q;
    assign pre_pixel_o = pre_q;

    // subtract the smaller from the larger so the result stays unsigned
    assign abs_diff_o = (crt_q >= pre_q) ? (crt_q - pre_q) : (pre_q - crt_q);

endmodule

/* src/sad_pixel_array.sv */
`timescale 1ns/1ps

module sad_pixel_array
    import sad_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  crt_keep_i,
    input  pix_row_t              crt_row_i,
    input  pix_row_t              pre_row_i,
    output pixel_t [NUM_PE-1:0]   abs_diff_o,
    output logic                  array_full_o
);

    // link[r] feeds grid row r, link[0] comes straight from the input rows
    pixel_t crt_link [BLOCK_DIM+1][BLOCK_DIM];
    pixel_t pre_link [BLOCK_DIM+1][BLOCK_DIM];

    fill_cnt_t fill_cnt;

    genvar r;
    genvar c;

    generate
        for (c = 0; c < BLOCK_DIM; c++) begin : g_col_in
            // column 0 is the leftmost pixel, which sits in the top bits of the row
            assign crt_link[0][c] = crt_row_i[(BLOCK_DIM-1-c)*PIXEL_W +: PIXEL_W];
            assign pre_link[0][c] = pre_row_i[(BLOCK_DIM-1-c)*PIXEL_W +: PIXEL_W];
        end

        for (r = 0; r < BLOCK_DIM; r++) begin : g_row
            for (c = 0; c < BLOCK_DIM; c++) begin : g_col
                sad_pe u_pe (
                    .clk         (clk),
                    .rst         (rst),
                    .crt_keep_i  (crt_keep_i),
                    .crt_pixel_i (crt_link[r][c]),
                    .pre_pixel_i (pre_link[r][c]),
                    .crt_pixel_o (crt_link[r+1][c]),
                    .pre_pixel_o (pre_link[r+1][c]),
                    .abs_diff_o  (abs_diff_o[r*BLOCK_DIM + c])
                );
            end
        end
    endgenerate

    // one reference row enters per cycle, so the grid is full after BLOCK_DIM edges
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_cnt <= '0;
        end else if (fill_cnt != fill_cnt_t'(BLOCK_DIM)) begin
            fill_cnt <= fill_cnt + fill_cnt_t'(1);
        end
    end

    assign array_full_o = (fill_cnt == fill_cnt_t'(BLOCK_DIM));

endmodule

/* src/sad_row_sum.sv */
`timescale 1ns/1ps

module sad_row_sum
    import sad_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  pixel_t   [NUM_PE-1:0]      abs_diff_i,
    input  logic                       array_full_i,
    output row_sum_t [BLOCK_DIM-1:0]   row_sum_o,
    output logic                       row_valid_o
);

    row_sum_t [BLOCK_DIM-1:0] row_sum_d;

    // the differences arrive grouped by grid row, eight per row
    always_comb begin
        for (int r = 0; r < BLOCK_DIM; r++) begin
            row_sum_d[r] = '0;
            for (int c = 0; c < BLOCK_DIM; c++) begin
                row_sum_d[r] = row_sum_d[r] + row_sum_t'(abs_diff_i[r*BLOCK_DIM + c]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            row_sum_o   <= '0;
            row_valid_o <= 1'b0;
        end else begin
            row_sum_o   <= row_sum_d;
            row_valid_o <= array_full_i;             // stays aligned with the sums it marks
        end
    end

endmodule

/* src/sad_block_sum.sv */
`timescale 1ns/1ps

module sad_block_sum
    import sad_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  row_sum_t [BLOCK_DIM-1:0]   row_sum_i,
    input  logic                       row_valid_i,
    output sad_t                       sad_o,
    output logic                       sad_valid_o
);

    // each tree level grows by one bit so no carry is lost
    logic [ROW_SUM_W:0]   pair_sum [BLOCK_DIM/2];
    logic [ROW_SUM_W+1:0] quad_sum [BLOCK_DIM/4];
    sad_t                 block_sum;

    always_comb begin
        for (int i = 0; i < BLOCK_DIM/2; i++) begin
            pair_sum[i] = {1'b0, row_sum_i[2*i]} + {1'b0, row_sum_i[2*i+1]};
        end
        for (int i = 0; i < BLOCK_DIM/4; i++) begin
            quad_sum[i] = {1'b0, pair_sum[2*i]} + {1'b0, pair_sum[2*i+1]};
        end
    end

    assign block_sum = {1'b0, quad_sum[0]} + {1'b0, quad_sum[1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            sad_o       <= '0;
            sad_valid_o <= 1'b0;
        end else begin
            sad_o       <= block_sum;
            sad_valid_o <= row_valid_i;
        end
    end

endmodule

/* src/sad_top.sv */
`timescale 1ns/1ps

module sad_top
    import sad_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     crt_keep_i,
    input  pix_row_t crt_row_i,
    input  pix_row_t pre_row_i,
    output sad_t     sad_o,
    output logic     sad_valid_o
);

    // grid to row-sum stage
    pixel_t [NUM_PE-1:0] abs_diff;
    logic                array_full;

    // row-sum stage to block-sum stage
    row_sum_t [BLOCK_DIM-1:0] row_sum;
    logic                     row_valid;

    // the grid state after edge t shows up on sad_o after edge t+2
    sad_pixel_array u_pixel_array (
        .clk          (clk),
        .rst          (rst),
        .crt_keep_i   (crt_keep_i),
        .crt_row_i    (crt_row_i),
        .pre_row_i    (pre_row_i),
        .abs_diff_o   (abs_diff),
        .array_full_o (array_full)
    );

    sad_row_sum u_row_sum (
        .clk          (clk),
        .rst          (rst),
        .abs_diff_i   (abs_diff),
        .array_full_i (array_full),
        .row_sum_o    (row_sum),
        .row_valid_o  (row_valid)
    );

    sad_block_sum u_block_sum (
        .clk         (clk),
        .rst         (rst),
        .row_sum_i   (row_sum),
        .row_valid_i (row_valid),
        .sad_o       (sad_o),
        .sad_valid_o (sad_valid_o)
    );

endmodule

/* sim/sad_chk.sv */
`timescale 1ns/1ps

module sad_chk
    import sad_pkg::*;
(
    input logic clk,
    input logic rst,
    input sad_t sad_i,
    input logic sad_valid_i
);

    int fail_count = 0;

    // a reset edge leaves the valid flag low for the two cycles that follow it
    property valid_low_after_rst;
        @(posedge clk) rst |=> !sad_valid_i ##1 !sad_valid_i;
    endproperty

    // all 64 differences at 255 is the largest SAD a block can give
    property sad_in_range;
        @(posedge clk) disable iff (rst) sad_i <= sad_t'(NUM_PE * (2**PIXEL_W - 1));
    endproperty

    property valid_sticky;
        @(posedge clk) disable iff (rst) sad_valid_i |=> sad_valid_i;
    endproperty

    a_valid_low: assert property (valid_low_after_rst) else begin
        fail_count++;
        $error("sad_valid_o high within two cycles of a reset edge");
    end

    a_sad_range: assert property (sad_in_range) else begin
        fail_count++;
        $error("sad_o above the largest possible block SAD");
    end

    a_valid_sticky: assert property (valid_sticky) else begin
        fail_count++;
        $error("sad_valid_o dropped without a reset");
    end

endmodule

bind sad_top sad_chk u_chk (
    .clk         (clk),
    .rst         (rst),
    .sad_i       (sad_o),
    .sad_valid_i (sad_valid_o)
);

/* sim/sad_tb.sv */
`timescale 1ns/1ps

module sad_tb
    import sad_pkg::*;
();

    localparam int TEST_CYCLES    = 320;              // all six tests together
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;
    localparam int SAD_MAX        = NUM_PE * 255;

    logic     clk;
    logic     rst;
    logic     crt_keep;
    pix_row_t crt_row;
    pix_row_t pre_row;
    sad_t     sad;
    logic     sad_valid;

    // reference model of the grid and of the two result stages
    pixel_t crt_m [BLOCK_DIM][BLOCK_DIM];
    pixel_t pre_m [BLOCK_DIM][BLOCK_DIM];
    int     fill;
    int     low_edges;                                // edges with rst low since the last reset
    sad_t   sad_hist  [3];
    logic   full_hist [3];

    logic [31:0] rand_state = 32'd67206;
    int          errors     = 0;
    int          checks     = 0;
    int          cycle_cnt  = 0;

    sad_top UUT (
        .clk         (clk),
        .rst         (rst),
        .crt_keep_i  (crt_keep),
        .crt_row_i   (crt_row),
        .pre_row_i   (pre_row),
        .sad_o       (sad),
        .sad_valid_o (sad_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    function automatic pix_row_t random_row();
        pix_row_t    row;
        logic [31:0] r;
        row = '0;
        for (int c = 0; c < BLOCK_DIM; c++) begin
            r   = next_rand();
            row = {row[ROW_W-PIXEL_W-1:0], r[23:16]};   // upper bits of the LCG are less regular
        end
        return row;
    endfunction

    // leftmost pixel of a row sits in the top bits
    function automatic pixel_t row_pixel(pix_row_t row, int c);
        return row[(BLOCK_DIM-1-c)*PIXEL_W +: PIXEL_W];
    endfunction

    function automatic sad_t model_sad();
        int total;
        total = 0;
        for (int r = 0; r < BLOCK_DIM; r++) begin
            for (int c = 0; c < BLOCK_DIM; c++) begin
                if (crt_m[r][c] >= pre_m[r][c]) begin
                    total += int'(crt_m[r][c]) - int'(pre_m[r][c]);
                end else begin
                    total += int'(pre_m[r][c]) - int'(crt_m[r][c]);
                end
            end
        end
        return sad_t'(total);
    endfunction

    // applies the inputs the DUT sampled at this edge to the model
    task automatic update_model();
        if (rst) begin
            for (int r = 0; r < BLOCK_DIM; r++) begin
                for (int c = 0; c < BLOCK_DIM; c++) begin
                    crt_m[r][c] = '0;
                    pre_m[r][c] = '0;
                end
            end
            fill      = 0;
            low_edges = 0;
            for (int i = 0; i < 3; i++) begin
                sad_hist[i]  = '0;
                full_hist[i] = 1'b0;
            end
        end else begin
            for (int r = BLOCK_DIM-1; r > 0; r--) begin
                for (int c = 0; c < BLOCK_DIM; c++) begin
                    pre_m[r][c] = pre_m[r-1][c];
                    if (!crt_keep) crt_m[r][c] = crt_m[r-1][c];
                end
            end
            for (int c = 0; c < BLOCK_DIM; c++) begin
                pre_m[0][c] = row_pixel(pre_row, c);
                if (!crt_keep) crt_m[0][c] = row_pixel(crt_row, c);
            end
            if (fill < BLOCK_DIM) fill++;
            low_edges++;
            sad_hist[2]  = sad_hist[1];
            sad_hist[1]  = sad_hist[0];
            sad_hist[0]  = model_sad();
            full_hist[2] = full_hist[1];
            full_hist[1] = full_hist[0];
            full_hist[0] = (fill == BLOCK_DIM);
        end
    endtask

    task automatic check_sad(sad_t expected);
        checks++;
        assert (sad === expected) else begin
            errors++;
            $display("** Error at %0t: sad_o expected %0d, actual %0d", $time, expected, sad);
        end
    endtask

    task automatic check_valid(logic expected);
        checks++;
        assert (sad_valid === expected) else begin
            errors++;
            $display("** Error at %0t: sad_valid_o expected %0b, actual %0b",
                     $time, expected, sad_valid);
        end
    endtask

    // each clock the model takes the sampled inputs, then the next row is driven and checked
    task automatic run_cycle(pix_row_t crt, pix_row_t pre, logic keep, logic rst_val);
        @(posedge clk);
        update_model();
        crt_row  <= crt;
        pre_row  <= pre;
        crt_keep <= keep;
        rst      <= rst_val;
        @(negedge clk);
        check_sad(sad_hist[2]);                       // result of the grid two edges back
        check_valid(full_hist[2]);
    endtask

    task automatic apply_reset();
        if (!rst) run_cycle('0, '0, 1'b0, 1'b1);
        run_cycle('0, '0, 1'b0, 1'b1);                // released on the next driven cycle
    endtask

    task automatic expect_fill_timing();
        pix_row_t row;
        for (int i = 0; i < 12; i++) begin
            row = random_row();
            run_cycle(row, row, 1'b0, 1'b0);
            check_valid(low_edges >= 10);
        end
    endtask

    task automatic reset_and_fill();
        apply_reset();
        check_sad('0);
        check_valid(1'b0);
        expect_fill_timing();
    endtask

    task automatic equal_frames();
        pix_row_t row;
        for (int i = 0; i < 12; i++) begin
            row = random_row();
            run_cycle(row, row, 1'b0, 1'b0);
            if (full_hist[2]) check_sad('0);
        end
    endtask

    task automatic max_difference();
        for (int i = 0; i < 12; i++) begin
            run_cycle('1, '0, 1'b0, 1'b0);
        end
        check_sad(sad_t'(SAD_MAX));                   // eight full rows have reached the output
    endtask

    task automatic random_stream();
        for (int i = 0; i < 200; i++) begin
            run_cycle(random_row(), random_row(), 1'b0, 1'b0);
        end
    endtask

    task automatic block_hold();
        for (int i = 0; i < 8; i++) begin
            run_cycle(random_row(), random_row(), 1'b0, 1'b0);
        end
        // the current rows driven from here on must not enter the grid
        for (int i = 0; i < 40; i++) begin
            run_cycle(random_row(), random_row(), 1'b1, 1'b0);
        end
    endtask

    task automatic reset_mid_stream();
        for (int i = 0; i < 20; i++) begin
            run_cycle(random_row(), random_row(), 1'b0, 1'b0);
        end
        apply_reset();
        check_sad('0);
        check_valid(1'b0);
        expect_fill_timing();
    endtask

    initial begin
        rst      = 1'b1;
        crt_keep = 1'b0;
        crt_row  = '0;
        pre_row  = '0;

        reset_and_fill();
        equal_frames();
        max_difference();
        random_stream();
        block_hold();
        reset_mid_stream();

        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, UUT.u_chk.fail_count);
        if (errors == 0 && UUT.u_chk.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* filelist.f */
src/sad_pkg.sv
src/sad_pe.sv
src/sad_pixel_array.sv
src/sad_row_sum.sv
src/sad_block_sum.sv
src/sad_top.sv
sim/sad_chk.sv
sim/sad_tb.sv

/* Makefile */
VERILATOR := verilator
TOP       := sad_tb
RTL_TOP   := sad_top
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
VFLAGS    := --timing --assert
BIN_FLAGS := --binary -j 0
RUN_FLAGS := +verilator+error+limit+100
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(BIN_FLAGS) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
